/* src/fetch_pkg.sv */
`default_nettype none

// constants shared by the fetch stages.
package fetch_pkg;

  // all addresses and instruction words are this wide.
  localparam int XLEN = 32;

  // the first address fetched once reset is released.
  localparam logic [XLEN-1:0] RESET_VECTOR = 32'h8000_0000;

  // sequential fetch steps one 32-bit word at a time.
  localparam logic [XLEN-1:0] PC_STEP = 32'd4;

  // the instruction memory holds this many words.
  localparam int IMEM_WORDS = 256;
  localparam int IMEM_AW    = $clog2(IMEM_WORDS); // word index width.
  localparam int IMEM_LSB   = 2;                  // pc bits below the word index.

  // the fetch queue between predecode and decode.
  localparam int QUEUE_DEPTH = 4;                 // must stay a power of two.
  localparam int QUEUE_AW    = $clog2(QUEUE_DEPTH);

  // the count value that marks a full queue.
  localparam logic [QUEUE_AW:0] QUEUE_FULL = (QUEUE_AW + 1)'(QUEUE_DEPTH);

  // state encoding of the pc generator.
  localparam int PCG_STW = 2;
  localparam logic [PCG_STW-1:0] PCG_INIT = 2'd0; // waiting for the first cycle after reset.
  localparam logic [PCG_STW-1:0] PCG_CALC = 2'd1; // stepping the pc after an accepted address.
  localparam logic [PCG_STW-1:0] PCG_WAIT = 2'd2; // offering pc_o to the memory.

endpackage

`default_nettype wire

/* src/rv_instr_pkg.sv */
`default_nettype none

// rv32 instruction layouts that predecode needs to pick apart.
package rv_instr_pkg;

  // major opcodes recognized by predecode.
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;

  // j-type layout, the immediate is scrambled across the upper bits.
  typedef struct packed {
    logic       imm20;    // sign bit of the jump offset.
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;       // link register.
    logic [6:0] opcode;
  } j_type_t;

  // b-type layout, the offset is split around rs1, rs2 and funct3.
  typedef struct packed {
    logic       imm12;    // sign bit of the branch offset.
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;   // compare kind.
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_type_t;

  // one instruction word seen raw, as a jump or as a branch.
  // the opcode sits in bits 6 to 0 in every view.
  typedef union packed {
    logic [31:0] raw;
    j_type_t     j;
    b_type_t     b;
  } instr_u;

endpackage

`default_nettype wire

/* src/pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// pc generator.
// it offers one fetch address at a time and steps by four after each
// accepted address. a redirect replaces the pc from any state.
module pc_gen (
  input  wire logic                       clock,
  input  wire logic                       reset,
  input  wire logic                       flush_i,       // load redirect_pc_i at the next edge.
  input  wire logic [fetch_pkg::XLEN-1:0] redirect_pc_i,
  output logic                            valid_o,
  input  wire logic                       ready_i,
  output logic [fetch_pkg::XLEN-1:0]      pc_o
);

  logic [fetch_pkg::PCG_STW-1:0] state_q; // current fsm state.
  logic [fetch_pkg::PCG_STW-1:0] state_d; // state for the next cycle without a redirect.
  logic [fetch_pkg::XLEN-1:0]    pc_q;    // address currently offered or being stepped.

  // an address is offered only while waiting for ready.
  assign valid_o = (state_q == fetch_pkg::PCG_WAIT);
  assign pc_o    = pc_q;

  // state register, a redirect always lands in the offering state.
  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= fetch_pkg::PCG_INIT;
    end else if (flush_i) begin
      state_q <= fetch_pkg::PCG_WAIT;
    end else begin
      state_q <= state_d;
    end
  end

  // init leaves after one cycle, calculate lasts one cycle.
  always_comb begin
    state_d = state_q;
    case (state_q)
      fetch_pkg::PCG_INIT: begin
        state_d = fetch_pkg::PCG_WAIT; // start-up delay of a single cycle.
      end
      fetch_pkg::PCG_CALC: begin
        state_d = fetch_pkg::PCG_WAIT;
      end
      fetch_pkg::PCG_WAIT: begin
        if (ready_i) begin
          state_d = fetch_pkg::PCG_CALC; // address taken, go compute the next one.
        end
      end
      default: begin
        state_d = fetch_pkg::PCG_INIT; // unused encoding, restart cleanly.
      end
    endcase
  end

  // pc register.
  // the reset vector is loaded on the way out of init.
  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q <= '0;
    end else if (flush_i) begin
      pc_q <= redirect_pc_i;                   // redirect from back end or predecode.
    end else if (state_q == fetch_pkg::PCG_INIT) begin
      pc_q <= fetch_pkg::RESET_VECTOR;
    end else if (state_q == fetch_pkg::PCG_CALC) begin
      pc_q <= pc_q + fetch_pkg::PC_STEP;       // next sequential word.
    end
  end

  // only word addresses ever leave this stage.
  a_pc_aligned: assert property (@(posedge clock) disable iff (reset)
    valid_o |-> (pc_o[1:0] == 2'b00));

  // a stalled address stays on offer until it is taken or redirected.
  a_pc_hold: assert property (@(posedge clock) disable iff (reset)
    (valid_o && !ready_i && !flush_i) |=> (valid_o && $stable(pc_o)));

endmodule

`default_nettype wire

/* src/imem_rom.sv */
`timescale 1ns/1ps
`default_nettype none

// instruction memory.
// it has one write port for loading and one synchronous read port
// feeding a single output register that carries the pc along.
module imem_rom (
  input  wire logic                          clock,
  input  wire logic                          reset,
  input  wire logic                          flush_i,  // drops the held word.
  input  wire logic                          we_i,     // single-cycle load strobe.
  input  wire logic [fetch_pkg::IMEM_AW-1:0] waddr_i,  // word index of the load.
  input  wire logic [fetch_pkg::XLEN-1:0]    wdata_i,
  input  wire logic                          valid_i,
  output logic                               ready_o,
  input  wire logic [fetch_pkg::XLEN-1:0]    pc_i,
  output logic                               valid_o,
  input  wire logic                          ready_i,
  output logic [fetch_pkg::XLEN-1:0]         instr_o,
  output logic [fetch_pkg::XLEN-1:0]         pc_o
);

  logic [fetch_pkg::XLEN-1:0]    mem_q [fetch_pkg::IMEM_WORDS]; // instruction words.
  logic [fetch_pkg::IMEM_AW-1:0] raddr;   // word index taken from the pc.
  logic                          accept;  // an address is taken this cycle.
  logic                          valid_q; // the output register holds a word.
  logic [fetch_pkg::XLEN-1:0]    instr_q;
  logic [fetch_pkg::XLEN-1:0]    pc_q;

  // upper pc bits are ignored, so fetch wraps around the memory.
  assign raddr = pc_i[fetch_pkg::IMEM_AW+fetch_pkg::IMEM_LSB-1:fetch_pkg::IMEM_LSB];

  // take a new address when the register is empty or drains this cycle.
  assign ready_o = !valid_q || ready_i;
  assign accept  = valid_i && ready_o;

  assign valid_o = valid_q;
  assign instr_o = instr_q;
  assign pc_o    = pc_q;

  // load port, no back-pressure.
  always_ff @(posedge clock) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // synchronous read straight into the output register.
  always_ff @(posedge clock) begin
    if (accept) begin
      instr_q <= mem_q[raddr];
      pc_q    <= pc_i; // the pc travels with its word.
    end
  end

  // occupancy of the output register.
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;   // wrong-path word or address, drop it.
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;   // drained with nothing behind it.
    end
  end

  // loads only happen while the pc generator is held off.
  a_no_load_during_fetch: assert property (@(posedge clock) disable iff (reset)
    we_i |-> !valid_i);

endmodule

`default_nettype wire

/* src/branch_predecode.sv */
`timescale 1ns/1ps
`default_nettype none

// static predecode stage.
// jal is always taken and a conditional branch is taken when it jumps
// backwards. a taken prediction redirects fetch as the word is accepted.
module branch_predecode (
  input  wire logic                       clock,
  input  wire logic                       reset,
  input  wire logic                       flush_i,
  input  wire logic                       valid_i,
  output logic                            ready_o,
  input  wire logic [fetch_pkg::XLEN-1:0] instr_i,
  input  wire logic [fetch_pkg::XLEN-1:0] pc_i,
  output logic                            valid_o,
  input  wire logic                       ready_i,
  output logic [fetch_pkg::XLEN-1:0]      instr_o,
  output logic [fetch_pkg::XLEN-1:0]      pc_o,
  output logic                            taken_o,
  output logic                            redirect_o, // one-cycle strobe toward the pc generator.
  output logic [fetch_pkg::XLEN-1:0]      target_o
);

  rv_instr_pkg::instr_u       word;      // incoming word in both views.
  logic [fetch_pkg::XLEN-1:0] j_imm;     // sign-extended jump offset.
  logic [fetch_pkg::XLEN-1:0] b_imm;     // sign-extended branch offset.
  logic                       is_jal;
  logic                       is_branch;
  logic                       predict;   // predicted taken.
  logic                       accept;
  logic                       valid_q;
  logic [fetch_pkg::XLEN-1:0] instr_q;
  logic [fetch_pkg::XLEN-1:0] pc_q;
  logic                       taken_q;

  assign word = instr_i;

  // reassemble the scattered immediates, bit 0 is always zero.
  assign j_imm = {{11{word.j.imm20}}, word.j.imm20, word.j.imm19_12,
                  word.j.imm11, word.j.imm10_1, 1'b0};
  assign b_imm = {{19{word.b.imm12}}, word.b.imm12, word.b.imm11,
                  word.b.imm10_5, word.b.imm4_1, 1'b0};

  assign is_jal    = (word.j.opcode == rv_instr_pkg::OPC_JAL);
  assign is_branch = (word.b.opcode == rv_instr_pkg::OPC_BRANCH);
  assign predict   = is_jal || (is_branch && word.b.imm12); // negative offset means a loop.

  assign target_o = pc_i + (is_jal ? j_imm : b_imm);

  assign ready_o = !valid_q || ready_i; // same acceptance rule as the memory stage.
  assign accept  = valid_i && ready_o;

  // a back-end flush already owns the redirect, so stay quiet then.
  assign redirect_o = accept && predict && !flush_i;

  assign valid_o = valid_q;
  assign instr_o = instr_q;
  assign pc_o    = pc_q;
  assign taken_o = taken_q;

  always_ff @(posedge clock) begin
    if (accept) begin
      instr_q <= instr_i;
      pc_q    <= pc_i;
      taken_q <= predict;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // compressed code is not supported, so targets must be word aligned.
  a_target_aligned: assert property (@(posedge clock) disable iff (reset)
    redirect_o |-> (target_o[1:0] == 2'b00));

endmodule

`default_nettype wire

/* src/fetch_queue.sv */
`timescale 1ns/1ps
`default_nettype none

// fetch queue.
// a small circular buffer that decouples predecode from decode.
// it carries the instruction, its pc and the predicted taken bit.
module fetch_queue (
  input  wire logic                       clock,
  input  wire logic                       reset,
  input  wire logic                       flush_i,  // empties the queue.
  input  wire logic                       valid_i,
  output logic                            ready_o,
  input  wire logic [fetch_pkg::XLEN-1:0] instr_i,
  input  wire logic [fetch_pkg::XLEN-1:0] pc_i,
  input  wire logic                       taken_i,
  output logic                            valid_o,
  input  wire logic                       ready_i,
  output logic [fetch_pkg::XLEN-1:0]      instr_o,
  output logic [fetch_pkg::XLEN-1:0]      pc_o,
  output logic                            taken_o
);

  logic [fetch_pkg::XLEN-1:0]     instr_q [fetch_pkg::QUEUE_DEPTH];
  logic [fetch_pkg::XLEN-1:0]     pc_q    [fetch_pkg::QUEUE_DEPTH];
  logic                           taken_q [fetch_pkg::QUEUE_DEPTH];
  logic [fetch_pkg::QUEUE_AW-1:0] wr_ptr;  // next slot to write.
  logic [fetch_pkg::QUEUE_AW-1:0] rd_ptr;  // oldest entry.
  logic [fetch_pkg::QUEUE_AW:0]   count;   // one bit wider than the pointers.
  logic                           push;
  logic                           pop;

  assign ready_o = (count != fetch_pkg::QUEUE_FULL);
  // a flush cycle shows nothing because the head may be on the wrong path.
  assign valid_o = (count != '0) && !flush_i;

  assign push = valid_i && ready_o && !flush_i;
  assign pop  = valid_o && ready_i;

  assign instr_o = instr_q[rd_ptr];
  assign pc_o    = pc_q[rd_ptr];
  assign taken_o = taken_q[rd_ptr];

  // each push writes its payload at the write pointer.
  always_ff @(posedge clock) begin
    if (push) begin
      instr_q[wr_ptr] <= instr_i;
      pc_q[wr_ptr]    <= pc_i;
      taken_q[wr_ptr] <= taken_i;
    end
  end

  // the pointers wrap on their own because the depth is a power of two.
  always_ff @(posedge clock) begin
    if (reset || flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // a push into a full queue or a pop from an empty one would carry the
  // count out of range.
  a_count_bound: assert property (@(posedge clock) disable iff (reset)
    count <= fetch_pkg::QUEUE_FULL);

  // an empty or a full queue has both pointers on the same slot.
  a_ptr_meet: assert property (@(posedge clock) disable iff (reset)
    ((count == '0) || (count == fetch_pkg::QUEUE_FULL)) |-> (wr_ptr == rd_ptr));

endmodule

`default_nettype wire

/* src/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

// fetch front end.
// pc generator, instruction memory, predecode and fetch queue in a row.
module fetch_unit (
  input  wire logic                          clock,
  input  wire logic                          reset,
  input  wire logic                          flush_i,       // back-end redirect.
  input  wire logic [fetch_pkg::XLEN-1:0]    redirect_pc_i,
  input  wire logic                          imem_we_i,
  input  wire logic [fetch_pkg::IMEM_AW-1:0] imem_waddr_i,
  input  wire logic [fetch_pkg::XLEN-1:0]    imem_wdata_i,
  output logic                               valid_o,
  input  wire logic                          ready_i,
  output logic [fetch_pkg::XLEN-1:0]         instr_o,
  output logic [fetch_pkg::XLEN-1:0]         pc_o,
  output logic                               taken_o
);

  logic                       pcg_valid;   // pc generator to memory.
  logic                       pcg_ready;
  logic [fetch_pkg::XLEN-1:0] pcg_pc;
  logic                       im_valid;    // memory to predecode.
  logic                       im_ready;
  logic [fetch_pkg::XLEN-1:0] im_instr;
  logic [fetch_pkg::XLEN-1:0] im_pc;
  logic                       pd_valid;    // predecode to queue.
  logic                       pd_ready;
  logic [fetch_pkg::XLEN-1:0] pd_instr;
  logic [fetch_pkg::XLEN-1:0] pd_pc;
  logic                       pd_taken;
  logic                       pd_redirect; // predicted-taken redirect.
  logic [fetch_pkg::XLEN-1:0] pd_target;
  logic                       fe_redirect; // merged redirect into the pc generator.
  logic [fetch_pkg::XLEN-1:0] fe_target;

  // the back end wins over predecode when both redirect together.
  assign fe_redirect = flush_i || pd_redirect;
  assign fe_target   = flush_i ? redirect_pc_i : pd_target;

  pc_gen u_pc_gen (
    .clock         (clock),
    .reset         (reset),
    .flush_i       (fe_redirect),
    .redirect_pc_i (fe_target),
    .valid_o       (pcg_valid),
    .ready_i       (pcg_ready),
    .pc_o          (pcg_pc)
  );

  // any redirect kills the memory word, it is younger than the branch.
  imem_rom u_imem_rom (
    .clock   (clock),
    .reset   (reset),
    .flush_i (fe_redirect),
    .we_i    (imem_we_i),
    .waddr_i (imem_waddr_i),
    .wdata_i (imem_wdata_i),
    .valid_i (pcg_valid),
    .ready_o (pcg_ready),
    .pc_i    (pcg_pc),
    .valid_o (im_valid),
    .ready_i (im_ready),
    .instr_o (im_instr),
    .pc_o    (im_pc)
  );

  branch_predecode u_branch_predecode (
    .clock      (clock),
    .reset      (reset),
    .flush_i    (flush_i),
    .valid_i    (im_valid),
    .ready_o    (im_ready),
    .instr_i    (im_instr),
    .pc_i       (im_pc),
    .valid_o    (pd_valid),
    .ready_i    (pd_ready),
    .instr_o    (pd_instr),
    .pc_o       (pd_pc),
    .taken_o    (pd_taken),
    .redirect_o (pd_redirect),
    .target_o   (pd_target)
  );

  fetch_queue u_fetch_queue (
    .clock   (clock),
    .reset   (reset),
    .flush_i (flush_i),
    .valid_i (pd_valid),
    .ready_o (pd_ready),
    .instr_i (pd_instr),
    .pc_i    (pd_pc),
    .taken_i (pd_taken),
    .valid_o (valid_o),
    .ready_i (ready_i),
    .instr_o (instr_o),
    .pc_o    (pc_o),
    .taken_o (taken_o)
  );

endmodule

`default_nettype wire

/* tests/tb_fetch_model.svh */
`ifndef TB_FETCH_MODEL_SVH
`define TB_FETCH_MODEL_SVH

// expected contents of the instruction memory, one word per index.
logic [31:0] image [fetch_pkg::IMEM_WORDS];

// builds a jal word from a byte offset and a link register.
function automatic logic [31:0] jal_word(input logic [20:0] off, input logic [4:0] rd);
  return {off[20], off[10:1], off[11], off[19:12], rd, 7'b110_1111};
endfunction

// builds a conditional branch comparing x1 with x2.
function automatic logic [31:0] branch_word(input logic [12:0] off, input logic [2:0] funct3);
  return {off[12], off[10:5], 5'd2, 5'd1, funct3, off[4:1], off[11], 7'b110_0011};
endfunction

// builds a plain addi x1, x0, imm, which never changes the flow.
function automatic logic [31:0] alu_word(input logic [11:0] imm);
  return {imm, 5'd0, 3'b000, 5'd1, 7'b001_0011};
endfunction

// static prediction of one fetched word.
// bit 32 of the result is the taken bit, bits 31 to 0 the next fetch pc.
function automatic logic [32:0] predict_next(input logic [31:0] pc, input logic [31:0] instr);
  logic [31:0] j_off;
  logic [31:0] b_off;
  logic [6:0]  opcode;
  opcode = instr[6:0];
  // jump offset bits come from 31, 19..12, 20 and 30..21.
  j_off = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  // branch offset bits come from 31, 7, 30..25 and 11..8.
  b_off = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  if (opcode == 7'b110_1111) begin
    return {1'b1, pc + j_off};         // jal is always followed.
  end
  if ((opcode == 7'b110_0011) && instr[31]) begin
    return {1'b1, pc + b_off};         // backward branch, assume a loop.
  end
  return {1'b0, pc + 32'd4};
endfunction

// index of the memory word that a pc selects, the memory wraps.
function automatic int word_index(input logic [31:0] pc);
  return int'(pc[9:2]);
endfunction

`endif

/* tests/tb_fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_unit;

  logic        clock;
  logic        reset;
  logic        flush_i;
  logic [31:0] redirect_pc_i;
  logic        imem_we_i;
  logic [7:0]  imem_waddr_i;
  logic [31:0] imem_wdata_i;
  logic        valid_o;
  logic        ready_i;
  logic [31:0] instr_o;
  logic [31:0] pc_o;
  logic        taken_o;

  logic [31:0] exp_pc;          // pc the next output word must carry.
  logic [31:0] exp_instr;
  logic [32:0] exp_next;
  int          transfers;       // words accepted at the output so far.
  int          pending_flushes; // flushes that hit a live predecode redirect.

  `include "tb_fetch_model.svh"

  fetch_unit u_dut (
    .clock         (clock),
    .reset         (reset),
    .flush_i       (flush_i),
    .redirect_pc_i (redirect_pc_i),
    .imem_we_i     (imem_we_i),
    .imem_waddr_i  (imem_waddr_i),
    .imem_wdata_i  (imem_wdata_i),
    .valid_o       (valid_o),
    .ready_i       (ready_i),
    .instr_o       (instr_o),
    .pc_o          (pc_o),
    .taken_o       (taken_o)
  );

  always #2 clock = ~clock; // 4 ns period.

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      fail_run($sformatf("output stream diverged at expected pc 0x%08h.", exp_pc));
    end
  endtask

  // the scoreboard follows the expected stream and compares every output transfer.
  initial begin
    forever begin
      @(posedge clock);
      if (reset) begin
        exp_pc = 32'h8000_0000; // fetch restarts at the reset vector.
      end else if (flush_i) begin
        check_value("valid_o", 32'(valid_o), 32'd0); // nothing leaves in a flush cycle.
        exp_pc = redirect_pc_i;
      end else if (valid_o && ready_i) begin
        exp_instr = image[word_index(exp_pc)];
        exp_next  = predict_next(exp_pc, exp_instr);
        check_value("pc_o", pc_o, exp_pc);
        check_value("instr_o", instr_o, exp_instr);
        check_value("taken_o", 32'(taken_o), 32'(exp_next[32]));
        exp_pc    = exp_next[31:0];
        transfers = transfers + 1;
      end
    end
  end

  // straight code, a forward jal, a forward branch and a backward loop.
  task automatic build_directed_image();
    for (int i = 0; i < fetch_pkg::IMEM_WORDS; i++) begin
      image[i] = alu_word(12'(i));
    end
    image[8]  = jal_word(21'd16, 5'd1);       // skips to word 12.
    image[13] = branch_word(13'd12, 3'b000);  // forward, predicted not taken.
    image[17] = branch_word(-13'sd12, 3'b001); // back to word 14, loops forever.
  endtask

  // a mix of jumps, branches both ways and plain alu words.
  task automatic build_random_image();
    int kind;
    for (int i = 0; i < fetch_pkg::IMEM_WORDS; i++) begin
      kind = $urandom_range(7);
      if (kind == 0) begin
        image[i] = jal_word(21'($urandom) & 21'h1f_fffc, 5'($urandom)); // word aligned.
      end else if (kind < 3) begin
        image[i] = branch_word(13'($urandom) & 13'h1ffc, 3'($urandom));
      end else begin
        image[i] = alu_word(12'($urandom));
      end
    end
  endtask

  // writes the whole image while the front end is held in reset.
  task automatic load_image();
    reset = 1'b1;
    for (int i = 0; i < fetch_pkg::IMEM_WORDS; i++) begin
      @(negedge clock);
      imem_we_i    = 1'b1;
      imem_waddr_i = i[7:0];
      imem_wdata_i = image[i];
    end
    @(negedge clock);
    imem_we_i = 1'b0;
    repeat (10) @(negedge clock); // reset stays up ten cycles after the last write.
    reset = 1'b0;
  endtask

  // drives ready and flush until count more words have left the queue.
  task automatic run_stream(input int count, input bit rand_ready, input bit rand_flush,
                            input logic [31:0] redirect_mask);
    int   target;
    int   waited;
    logic pending;
    logic flush_next;
    target = transfers + count;
    waited = 0;
    while (transfers < target) begin
      @(negedge clock);
      pending    = u_dut.pd_redirect; // a taken prediction is going out this cycle.
      flush_next = 1'b0;
      if (rand_flush) begin
        // flushes land more often on top of a predecode redirect.
        flush_next = (pending && ($urandom_range(3) == 0)) || ($urandom_range(39) == 0);
      end
      if (flush_next) begin
        redirect_pc_i = 32'h8000_0000 + ($urandom & redirect_mask);
        if (pending) begin
          pending_flushes = pending_flushes + 1;
        end
      end
      flush_i = flush_next;
      ready_i = rand_ready ? ($urandom_range(3) != 0) : 1'b1;
      waited  = waited + 1;
      if (waited > count * 20 + 100) begin
        fail_run($sformatf("timeout: %0d words seen at the output, %0d expected.",
                           transfers, target));
      end
    end
    @(negedge clock);
    flush_i = 1'b0;
  endtask

  initial begin
    void'($urandom(85121));
    clock           = 1'b0;
    reset           = 1'b1;
    flush_i         = 1'b0;
    redirect_pc_i   = '0;
    imem_we_i       = 1'b0;
    imem_waddr_i    = '0;
    imem_wdata_i    = '0;
    ready_i         = 1'b1;
    transfers       = 0;
    pending_flushes = 0;
    exp_pc          = 32'h8000_0000;

    build_directed_image();
    load_image();
    run_stream(40, 1'b0, 1'b0, 32'h0);       // straight code, jal and both branches.
    run_stream(300, 1'b1, 1'b1, 32'h7c);     // back-pressure and flushes in the program.

    reset = 1'b1; // hold the stream before the image changes.
    build_random_image();
    load_image();
    run_stream(2000, 1'b1, 1'b1, 32'hffff_fffc);

    if (pending_flushes == 0) begin
      fail_run("no flush ever met a pending predecode redirect.");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* fetch_unit.f */
+incdir+tests
src/fetch_pkg.sv
src/rv_instr_pkg.sv
src/pc_gen.sv
src/imem_rom.sv
src/branch_predecode.sv
src/fetch_queue.sv
src/fetch_unit.sv
tests/tb_fetch_unit.sv

/* Bender.yml */
package:
  name: fetch_unit

sources:
  # packages first, the modules use their scoped names.
  - src/fetch_pkg.sv
  - src/rv_instr_pkg.sv
  - src/pc_gen.sv
  - src/imem_rom.sv
  - src/branch_predecode.sv
  - src/fetch_queue.sv
  - src/fetch_unit.sv

  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_fetch_unit.sv
